// File: build.f
+incdir+source
source/tg_proto_pkg.sv
source/tg_mcb_pkg.sv
source/sync_fifo.sv
source/cmd_parser.sv
source/write_drain.sv
source/reply_builder.sv
source/tx_feeder.sv
source/traffic_generator.sv
verif/traffic_generator_checker.sv
verif/tb_traffic_generator.sv

// File: Bender.yml
package:
  name: traffic_generator

sources:
  - include_dirs:
      - source
    files:
      - source/tg_proto_pkg.sv
      - source/tg_mcb_pkg.sv
      - source/sync_fifo.sv
      - source/cmd_parser.sv
      - source/write_drain.sv
      - source/reply_builder.sv
      - source/tx_feeder.sv
      - source/traffic_generator.sv
  - target: test
    files:
      - verif/traffic_generator_checker.sv
      - verif/tb_traffic_generator.sv

// File: verif/tb_traffic_generator.sv
`timescale 1ns/1ps
`default_nettype none

module tb_traffic_generator;

	import tg_proto_pkg::*;
	import tg_mcb_pkg::*;

	localparam int byte_gap = 12;
	localparam int n_tests = 8;
	localparam logic [1:0] op_write = 2'd0;
	localparam logic [1:0] op_read = 2'd1;
	localparam logic [1:0] op_junk = 2'd2;

	typedef struct packed {
		logic [1:0] op;
		logic [31:0] addr;
		logic [5:0] len;
		logic bp;
	} test_t;

	logic clk;
	logic reset;
	logic rx_done_tick;
	byte_t rx_data_out;
	logic tx_start_transmission;
	byte_t tx_data_in;
	logic tx_busy;
	logic cmd_en;
	mcb_instr_t cmd_instr;
	mcb_bl_t cmd_bl;
	mcb_addr_t cmd_byte_addr;
	logic cmd_full;
	logic wr_en;
	mcb_word_t wr_data;
	logic wr_full;
	logic rd_en;
	mcb_word_t rd_data;
	logic rd_empty;

	test_t tests [n_tests];
	byte_t payload [n_tests][64];
	// expected bytes per word index, from what the host sent
	byte_t exp_mem [int];
	mcb_word_t mem [int];
	mcb_word_t wq [$];
	mcb_word_t rd_q [$];
	mcb_word_t wr_log [$];
	mcb_instr_t instr_log [$];
	mcb_addr_t addr_log [$];
	mcb_bl_t bl_log [$];
	byte_t tx_log [$];
	logic [31:0] rng;
	logic bp_on;
	logic rd_take;
	int busy_left;
	int words_at_cmd;
	int limit;
	int cycles;
	int val_errors;
	int other_errors;

	traffic_generator UUT (.*);

	always #5 clk = ~clk;

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	task automatic check_word(input string name, input mcb_word_t got, input mcb_word_t exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			val_errors++;
		end
	endtask

	task automatic check_addr(input string name, input mcb_addr_t got, input mcb_addr_t exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			val_errors++;
		end
	endtask

	task automatic check_bl(input string name, input mcb_bl_t got, input mcb_bl_t exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			val_errors++;
		end
	endtask

	task automatic check_instr(input string name, input mcb_instr_t got, input mcb_instr_t exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			val_errors++;
		end
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			val_errors++;
		end
	endtask

	// one received uart byte, then idle for the rest of the gap
	task automatic send_byte(input byte_t b);
		@(negedge clk);
		rx_data_out = b;
		rx_done_tick = 1'b1;
		@(negedge clk);
		rx_done_tick = 1'b0;
		repeat (byte_gap - 2) @(negedge clk);
	endtask

	task automatic store_cmd();
		int base;
		base = int'(cmd_byte_addr >> 2);
		instr_log.push_back(cmd_instr);
		addr_log.push_back(cmd_byte_addr);
		bl_log.push_back(cmd_bl);
		if (cmd_instr == MCB_WRITE_AP) begin
			words_at_cmd = wq.size();
			for (int i = 0; wq.size() > 0; i++) begin
				mem[base + i] = wq.pop_front();
			end
		end else begin
			for (int i = 0; i < cmd_bl; i++) begin
				rd_q.push_back(mem.exists(base + i) ? mem[base + i] : ~mcb_word_t'(base + i));
			end
		end
	endtask

	// controller and uart transmit models
	always @(negedge clk) begin : bus_models
		logic [31:0] r;
		r = next_rand();
		if (rd_take) begin
			void'(rd_q.pop_front());
		end
		rd_empty = (rd_q.size() == 0);
		rd_data = rd_empty ? '0 : rd_q[0];
		wr_full = bp_on && (r[1:0] == 2'd0);
		cmd_full = bp_on && (r[3:2] != 2'd0);
		if (tx_start_transmission) begin
			tx_log.push_back(tx_data_in);
			busy_left = 3;
		end else if (busy_left > 0) begin
			busy_left--;
			tx_busy = 1'b1;
		end else begin
			tx_busy = bp_on && (r[5:4] == 2'd0);
		end
		// inputs now hold until the rising edge, so these strobes are taken there
		#1;
		rd_take = rd_en;
		if (wr_en) begin
			wq.push_back(wr_data);
			wr_log.push_back(wr_data);
		end
		if (cmd_en) begin
			store_cmd();
		end
	end

	task automatic run_test(input int t);
		test_t tc;
		mcb_addr_t addr;
		int base;
		int n_wr;
		int n_cmd;
		int n_tx;
		tc = tests[t];
		addr = tc.addr[29:0];
		base = int'(addr >> 2);
		n_wr = (tc.op == op_write) ? tc.len : 0;
		n_cmd = (tc.op == op_junk) ? 0 : 1;
		n_tx = (tc.op == op_junk) ? 0 : ((tc.op == op_write) ? 1 : tc.len + 1);
		wr_log.delete();
		instr_log.delete();
		addr_log.delete();
		bl_log.delete();
		tx_log.delete();
		bp_on = tc.bp;
		if (tc.op == op_junk) begin
			// a whole frame behind a byte that is no start byte
			send_byte(tc.addr[31:24]);
		end else begin
			send_byte((tc.op == op_write) ? WRITE_START : READ_START);
		end
		for (int i = 3; i >= 0; i--) begin
			send_byte(tc.addr[8*i +: 8]);
		end
		send_byte(byte_t'(tc.len));
		for (int i = 0; i < n_wr; i++) begin
			exp_mem[base + i] = payload[t][i];
			send_byte(payload[t][i]);
		end
		if (tc.op == op_junk) begin
			for (int i = 0; i < tc.len; i++) begin
				send_byte(tc.addr[7:0]);
			end
		end
		while (tx_log.size() < n_tx) begin
			@(negedge clk);
		end
		// room for anything extra to show up
		repeat (40) @(negedge clk);
		bp_on = 1'b0;
		if (wr_log.size() != n_wr || instr_log.size() != n_cmd || tx_log.size() != n_tx) begin
			$display("test %0d saw %0d write words, %0d commands and %0d reply bytes",
				t, wr_log.size(), instr_log.size(), tx_log.size());
			$display("test %0d expected %0d write words, %0d commands and %0d reply bytes",
				t, n_wr, n_cmd, n_tx);
			other_errors++;
		end else begin
			for (int i = 0; i < n_wr; i++) begin
				check_word("wr_data", wr_log[i], mcb_word_t'(payload[t][i]));
			end
			if (n_cmd == 1) begin
				check_instr("cmd_instr", instr_log[0],
					(tc.op == op_write) ? MCB_WRITE_AP : MCB_READ_AP);
				check_addr("cmd_byte_addr", addr_log[0], addr);
				check_bl("cmd_bl", bl_log[0], tc.len);
			end
			for (int i = 0; i + 1 < n_tx; i++) begin
				check_byte("tx_data_in", tx_log[i], exp_mem[base + i]);
			end
			if (n_tx > 0) begin
				check_byte("tx_data_in", tx_log[n_tx - 1], DONE_BYTE);
			end
			if (tc.op == op_write && words_at_cmd != tc.len) begin
				$display("test %0d write command came with %0d of %0d words delivered",
					t, words_at_cmd, tc.len);
				other_errors++;
			end
		end
	endtask

	initial begin : main
		logic [31:0] r;
		int total;
		int assert_errors;
		clk = 1'b0;
		reset = 1'b1;
		rx_done_tick = 1'b0;
		rx_data_out = '0;
		tx_busy = 1'b0;
		cmd_full = 1'b0;
		wr_full = 1'b0;
		rd_data = '0;
		rd_empty = 1'b1;
		rng = 32'd98956;
		bp_on = 1'b0;
		rd_take = 1'b0;
		busy_left = 0;
		words_at_cmd = 0;
		cycles = 0;
		val_errors = 0;
		other_errors = 0;
		// op, 32-bit address as sent, length, back-pressure
		tests[0] = '{op_write, 32'h0000_0100, 6'd4, 1'b0};
		tests[1] = '{op_read, 32'h0000_0100, 6'd4, 1'b0};
		tests[2] = '{op_junk, 32'h551E_00AA, 6'd2, 1'b0};
		tests[3] = '{op_write, 32'hC000_0200, 6'd63, 1'b1};
		tests[4] = '{op_read, 32'h4000_0200, 6'd63, 1'b1};
		tests[5] = '{op_write, 32'h0000_0040, 6'd1, 1'b1};
		tests[6] = '{op_read, 32'h0000_0040, 6'd1, 1'b0};
		tests[7] = '{op_read, 32'h0000_0200, 6'd10, 1'b1};
		total = 2000;
		for (int t = 0; t < n_tests; t++) begin
			total += (6 + tests[t].len) * byte_gap * 4;
			for (int i = 0; i < 64; i++) begin
				r = next_rand();
				payload[t][i] = r[7:0];
			end
		end
		limit = total;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		for (int t = 0; t < n_tests; t++) begin
			run_test(t);
		end
		assert_errors = UUT.u_checker.fail_count;
		$display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
			val_errors, other_errors, assert_errors);
		if (val_errors + other_errors + assert_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout, the run did not finish within %0d cycles", limit);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/traffic_generator_checker.sv
`timescale 1ns/1ps
`default_nettype none

module traffic_generator_checker (
	input logic clk,
	input logic reset,
	input logic cmd_en,
	input logic cmd_full,
	input logic wr_en,
	input logic wr_full,
	input logic rd_en,
	input logic rd_empty,
	input logic tx_start_transmission,
	input logic tx_busy,
	input tg_proto_pkg::parser_state_t parser_state
);

	import tg_proto_pkg::*;

	// assertion failures so far
	int fail_count = 0;

	assert property (@(posedge clk) disable iff (reset) !(cmd_en && cmd_full))
		else begin
			$error("cmd_en raised while cmd_full is high");
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (reset) !(wr_en && wr_full))
		else begin
			$error("wr_en raised while wr_full is high");
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (reset) !(tx_start_transmission && tx_busy))
		else begin
			$error("tx_start_transmission raised while tx_busy is high");
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (reset) !(rd_en && rd_empty))
		else begin
			$error("rd_en raised while rd_empty is high");
			fail_count++;
		end

	// quiet outputs and an idle parser once a reset edge has been seen
	assert property (@(posedge clk) reset |=> (!cmd_en && !wr_en && !rd_en &&
			!tx_start_transmission && parser_state == ST_IDLE))
		else begin
			$error("control outputs active or parser busy under reset");
			fail_count++;
		end

endmodule

bind traffic_generator traffic_generator_checker u_checker (
	.clk(clk),
	.reset(reset),
	.cmd_en(cmd_en),
	.cmd_full(cmd_full),
	.wr_en(wr_en),
	.wr_full(wr_full),
	.rd_en(rd_en),
	.rd_empty(rd_empty),
	.tx_start_transmission(tx_start_transmission),
	.tx_busy(tx_busy),
	.parser_state(u_cmd_parser.state)
);

`default_nettype wire

// File: source/traffic_generator.sv
`timescale 1ns/1ps
`default_nettype none

module traffic_generator (
	input logic clk,
	input logic reset,
	// uart
	input logic rx_done_tick,
	input tg_proto_pkg::byte_t rx_data_out,
	output logic tx_start_transmission,
	output tg_proto_pkg::byte_t tx_data_in,
	input logic tx_busy,
	// controller command port
	output logic cmd_en,
	output tg_mcb_pkg::mcb_instr_t cmd_instr,
	output tg_mcb_pkg::mcb_bl_t cmd_bl,
	output tg_mcb_pkg::mcb_addr_t cmd_byte_addr,
	input logic cmd_full,
	// controller write data port
	output logic wr_en,
	output tg_mcb_pkg::mcb_word_t wr_data,
	input logic wr_full,
	// controller read data port
	output logic rd_en,
	input tg_mcb_pkg::mcb_word_t rd_data,
	input logic rd_empty
);

	import tg_proto_pkg::*;
	import tg_mcb_pkg::*;

	logic in_push;
	mcb_word_t in_word;
	logic in_drained;
	logic write_done;
	logic read_start;
	mcb_bl_t read_len;
	logic read_done;
	logic reply_push;
	byte_t reply_byte;

	cmd_parser u_cmd_parser (
		.clk(clk),
		.reset(reset),
		.rx_done_tick(rx_done_tick),
		.rx_data_out(rx_data_out),
		.in_drained(in_drained),
		.cmd_full(cmd_full),
		.read_done(read_done),
		.in_push(in_push),
		.in_word(in_word),
		.cmd_en(cmd_en),
		.cmd_instr(cmd_instr),
		.cmd_bl(cmd_bl),
		.cmd_byte_addr(cmd_byte_addr),
		.write_done(write_done),
		.read_start(read_start),
		.read_len(read_len)
	);

	write_drain u_write_drain (
		.clk(clk),
		.reset(reset),
		.in_push(in_push),
		.in_word(in_word),
		.wr_full(wr_full),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.in_drained(in_drained)
	);

	reply_builder u_reply_builder (
		.clk(clk),
		.reset(reset),
		.write_done(write_done),
		.read_start(read_start),
		.read_len(read_len),
		.rd_data(rd_data),
		.rd_empty(rd_empty),
		.rd_en(rd_en),
		.read_done(read_done),
		.reply_push(reply_push),
		.reply_byte(reply_byte)
	);

	tx_feeder u_tx_feeder (
		.clk(clk),
		.reset(reset),
		.reply_push(reply_push),
		.reply_byte(reply_byte),
		.tx_busy(tx_busy),
		.tx_start_transmission(tx_start_transmission),
		.tx_data_in(tx_data_in)
	);

endmodule

`default_nettype wire

// File: source/tx_feeder.sv
`timescale 1ns/1ps
`include "tg_macros.svh"
`default_nettype none

module tx_feeder (
	input logic clk,
	input logic reset,
	input logic reply_push,
	input tg_proto_pkg::byte_t reply_byte,
	input logic tx_busy,
	output logic tx_start_transmission,
	output tg_proto_pkg::byte_t tx_data_in
);

	logic fifo_empty;
	logic fifo_pop;
	logic [`TG_BYTE_W-1:0] head_byte;

	// uart raises tx_busy only a cycle after the start strobe
	assign fifo_pop = !fifo_empty && !tx_busy && !tx_start_transmission;

	// reply buffer
	sync_fifo #(
		.width(`TG_BYTE_W),
		.depth(`TG_OUT_DEPTH)
	) u_reply_fifo (
		.clk(clk),
		.reset(reset),
		.push(reply_push),
		.pop(fifo_pop),
		.push_data(reply_byte),
		.pop_data(head_byte),
		.empty(fifo_empty)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			tx_start_transmission <= 1'b0;
		end else begin
			tx_start_transmission <= fifo_pop;
		end
	end

	always_ff @(posedge clk) begin
		if (fifo_pop) begin
			tx_data_in <= head_byte;
		end
	end

endmodule

`default_nettype wire

// File: source/reply_builder.sv
`timescale 1ns/1ps
`include "tg_macros.svh"
`default_nettype none

module reply_builder (
	input logic clk,
	input logic reset,
	input logic write_done,
	input logic read_start,
	input tg_mcb_pkg::mcb_bl_t read_len,
	input tg_mcb_pkg::mcb_word_t rd_data,
	input logic rd_empty,
	output logic rd_en,
	output logic read_done,
	output logic reply_push,
	output tg_proto_pkg::byte_t reply_byte
);

	import tg_proto_pkg::*;
	import tg_mcb_pkg::*;

	// words still to pop in the current read
	mcb_bl_t remaining;
	logic rd_en_q;
	logic last_q;

	// skip a cycle after each pop, rd_empty lags by one
	assign rd_en = (remaining != '0) && !rd_empty && !rd_en_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			remaining <= '0;
			rd_en_q <= 1'b0;
			last_q <= 1'b0;
			read_done <= 1'b0;
			reply_push <= 1'b0;
		end else begin
			if (read_start) begin
				remaining <= read_len;
			end else if (rd_en) begin
				remaining <= remaining - 1'b1;
			end
			rd_en_q <= rd_en;
			last_q <= rd_en && (remaining == mcb_bl_t'(1));
			// done marker follows the last data byte
			read_done <= last_q;
			reply_push <= rd_en || last_q || write_done;
		end
	end

	always_ff @(posedge clk) begin
		reply_byte <= rd_en ? rd_data[`TG_BYTE_W-1:0] : DONE_BYTE;
	end

endmodule

`default_nettype wire

// File: source/write_drain.sv
`timescale 1ns/1ps
`include "tg_macros.svh"
`default_nettype none

module write_drain (
	input logic clk,
	input logic reset,
	input logic in_push,
	input tg_mcb_pkg::mcb_word_t in_word,
	input logic wr_full,
	output logic wr_en,
	output tg_mcb_pkg::mcb_word_t wr_data,
	output logic in_drained
);

	logic fifo_empty;

	// one word per cycle while the controller has room
	assign wr_en = !fifo_empty && !wr_full;
	assign in_drained = fifo_empty;

	// input buffer
	sync_fifo #(
		.width(`TG_DATA_W),
		.depth(`TG_IN_DEPTH)
	) u_in_fifo (
		.clk(clk),
		.reset(reset),
		.push(in_push),
		.pop(wr_en),
		.push_data(in_word),
		.pop_data(wr_data),
		.empty(fifo_empty)
	);

endmodule

`default_nettype wire

// File: source/cmd_parser.sv
`timescale 1ns/1ps
`include "tg_macros.svh"
`default_nettype none

module cmd_parser (
	input logic clk,
	input logic reset,
	input logic rx_done_tick,
	input tg_proto_pkg::byte_t rx_data_out,
	input logic in_drained,
	input logic cmd_full,
	input logic read_done,
	output logic in_push,
	output tg_mcb_pkg::mcb_word_t in_word,
	output logic cmd_en,
	output tg_mcb_pkg::mcb_instr_t cmd_instr,
	output tg_mcb_pkg::mcb_bl_t cmd_bl,
	output tg_mcb_pkg::mcb_addr_t cmd_byte_addr,
	output logic write_done,
	output logic read_start,
	output tg_mcb_pkg::mcb_bl_t read_len
);

	import tg_proto_pkg::*;
	import tg_mcb_pkg::*;

	localparam int addr_cnt_w = $clog2(`TG_ADDR_BYTES);

	parser_state_t state;
	logic [addr_cnt_w-1:0] addr_cnt;
	mcb_bl_t data_cnt;
	logic wr_go;
	logic rd_go;

	// write command waits until the last pushed word has left the buffer
	assign wr_go = (state == ST_WR_CMD) && in_drained && !in_push && !cmd_full;
	assign rd_go = (state == ST_RD_CMD) && !cmd_full;

	assign cmd_en = wr_go || rd_go;
	assign write_done = wr_go;
	assign read_start = rd_go;
	assign read_len = cmd_bl;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			addr_cnt <= '0;
			data_cnt <= '0;
			in_push <= 1'b0;
		end else begin
			in_push <= 1'b0;
			case (state)
				ST_IDLE: begin
					// anything but a start byte is dropped here
					if (rx_done_tick && (rx_data_out == WRITE_START ||
							rx_data_out == READ_START)) begin
						addr_cnt <= '0;
						state <= ST_ADDR;
					end
				end
				ST_ADDR: begin
					if (rx_done_tick) begin
						addr_cnt <= addr_cnt + 1'b1;
						if (addr_cnt == addr_cnt_w'(`TG_ADDR_BYTES - 1)) begin
							state <= ST_LEN;
						end
					end
				end
				ST_LEN: begin
					if (rx_done_tick) begin
						data_cnt <= '0;
						state <= (cmd_instr == MCB_WRITE_AP) ? ST_WR_DATA : ST_RD_CMD;
					end
				end
				ST_WR_DATA: begin
					if (rx_done_tick) begin
						in_push <= 1'b1;
						data_cnt <= data_cnt + 1'b1;
						if (data_cnt == mcb_bl_t'(cmd_bl - 1'b1)) begin
							state <= ST_WR_CMD;
						end
					end
				end
				ST_WR_CMD: begin
					if (wr_go) begin
						state <= ST_IDLE;
					end
				end
				ST_RD_CMD: begin
					if (rd_go) begin
						state <= ST_RD_WAIT;
					end
				end
				ST_RD_WAIT: begin
					// reply side has queued all read bytes
					if (read_done) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// command fields and the payload word
	always_ff @(posedge clk) begin
		if (rx_done_tick) begin
			in_word <= {{(`TG_DATA_W - `TG_BYTE_W){1'b0}}, rx_data_out};
			case (state)
				ST_IDLE: begin
					cmd_instr <= (rx_data_out == READ_START) ? MCB_READ_AP : MCB_WRITE_AP;
				end
				ST_ADDR: begin
					// msb first, top two bits fall off
					cmd_byte_addr <= {cmd_byte_addr[`TG_ADDR_W-`TG_BYTE_W-1:0], rx_data_out};
				end
				ST_LEN: begin
					cmd_bl <= rx_data_out[`TG_BL_W-1:0];
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int width = 8,
	parameter int depth = 16
) (
	input logic clk,
	input logic reset,
	input logic push,
	input logic pop,
	input logic [width-1:0] push_data,
	output logic [width-1:0] pop_data,
	output logic empty
);

	localparam int ptr_w = $clog2(depth);

	logic [width-1:0] mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w:0] count;
	logic do_push;
	logic do_pop;

	// full push and empty pop are dropped
	assign do_push = push && (count != (ptr_w + 1)'(depth));
	assign do_pop = pop && !empty;

	assign empty = (count == '0);
	// show-ahead head word
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + do_push - do_pop;
		end
	end

endmodule

`default_nettype wire

// File: source/tg_mcb_pkg.sv
`include "tg_macros.svh"
`default_nettype none

package tg_mcb_pkg;

	// command codes of the controller user port
	typedef enum logic [2:0] {
		MCB_WRITE = 3'd0,
		MCB_READ = 3'd1,
		MCB_WRITE_AP = 3'd2,
		MCB_READ_AP = 3'd3
	} mcb_instr_t;

	typedef logic [`TG_ADDR_W-1:0] mcb_addr_t;
	typedef logic [`TG_DATA_W-1:0] mcb_word_t;
	typedef logic [`TG_BL_W-1:0] mcb_bl_t;

endpackage

`default_nettype wire

// File: source/tg_proto_pkg.sv
`include "tg_macros.svh"
`default_nettype none

package tg_proto_pkg;

	typedef logic [`TG_BYTE_W-1:0] byte_t;

	// frame start bytes from the host
	localparam byte_t WRITE_START = 8'hFF;
	localparam byte_t READ_START = 8'hFE;

	// closes every reply
	localparam byte_t DONE_BYTE = 8'h1E;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ADDR,
		ST_LEN,
		ST_WR_DATA,
		ST_WR_CMD,
		ST_RD_CMD,
		ST_RD_WAIT
	} parser_state_t;

endpackage

`default_nettype wire

// File: source/tg_macros.svh
`ifndef TG_MACROS_SVH
`define TG_MACROS_SVH
`default_nettype none

// uart side
`define TG_BYTE_W 8
`define TG_ADDR_BYTES 4

// memory controller side
`define TG_ADDR_W 30
`define TG_DATA_W 32
`define TG_BL_W 6

// buffer sizes, words
`define TG_IN_DEPTH 64
`define TG_OUT_DEPTH 128

`default_nettype wire
`endif
